// ==== rtl/controlUnit.sv ====
`timescale 1ns/1ps
`default_nettype none

module controlUnit (
	input cpuPkg::instrT instr,
	output logic regWrite,
	output logic regDst, // 1 picks rd, 0 picks rt
	output logic aluSrc, // 1 picks the immediate
	output logic memRead,
	output logic memWrite,
	output logic memToReg,
	output logic branch,
	output logic [1:0] aluOp
);

	logic functKnown;

	// R-type words with other funct values (the all-zero nop too) act as bubbles
	assign functKnown = instr.r.funct inside {cpuPkg::fnAdd, cpuPkg::fnSub,
		cpuPkg::fnAnd, cpuPkg::fnOr, cpuPkg::fnSlt};

	always_comb
	begin
		regWrite = 1'b0;
		regDst = 1'b0;
		aluSrc = 1'b0;
		memRead = 1'b0;
		memWrite = 1'b0;
		memToReg = 1'b0;
		branch = 1'b0;
		aluOp = cpuPkg::aluClassAdd;
		case (instr.i.opcode)
			cpuPkg::opR:
			begin
				regWrite = functKnown;
				regDst = 1'b1;
				aluOp = cpuPkg::aluClassFunct;
			end
			cpuPkg::opLw:
			begin
				regWrite = 1'b1;
				aluSrc = 1'b1; // base + offset
				memRead = 1'b1;
				memToReg = 1'b1;
			end
			cpuPkg::opSw:
			begin
				aluSrc = 1'b1;
				memWrite = 1'b1;
			end
			cpuPkg::opBeq:
			begin
				branch = 1'b1; // compared in ID, EX result unused
				aluOp = cpuPkg::aluClassSub;
			end
			default: ; // unknown opcode, all clear
		endcase
	end

endmodule

`default_nettype wire

// ==== rtl/cpuPkg.sv ====
`default_nettype none

package cpuPkg;

	localparam int dataWidth = 32;
	localparam int regAddrWidth = 5;

	// major opcodes
	localparam logic [5:0] opR = 6'h00;
	localparam logic [5:0] opLw = 6'h23;
	localparam logic [5:0] opSw = 6'h2b;
	localparam logic [5:0] opBeq = 6'h04;

	// funct field of R-type
	localparam logic [5:0] fnAdd = 6'h20;
	localparam logic [5:0] fnSub = 6'h22;
	localparam logic [5:0] fnAnd = 6'h24;
	localparam logic [5:0] fnOr = 6'h25;
	localparam logic [5:0] fnSlt = 6'h2a;

	// aluOp from control, refined in EX
	localparam logic [1:0] aluClassAdd = 2'b00; // lw, sw address
	localparam logic [1:0] aluClassSub = 2'b01; // beq
	localparam logic [1:0] aluClassFunct = 2'b10; // look at funct

	// ALU operation codes
	localparam logic [3:0] aluAnd = 4'b0000;
	localparam logic [3:0] aluOr = 4'b0001;
	localparam logic [3:0] aluAdd = 4'b0010;
	localparam logic [3:0] aluSub = 4'b0110;
	localparam logic [3:0] aluSlt = 4'b0111;

	// operand source in EX
	localparam logic [1:0] fwdNone = 2'b00; // register file value
	localparam logic [1:0] fwdWb = 2'b01; // MEM/WB writeback value
	localparam logic [1:0] fwdMem = 2'b10; // EX/MEM ALU result

	// one word, two field layouts
	typedef union packed {
		struct packed {
			logic [5:0] opcode;
			logic [regAddrWidth-1:0] rs;
			logic [regAddrWidth-1:0] rt;
			logic [regAddrWidth-1:0] rd;
			logic [4:0] shamt; // no shifts, field ignored
			logic [5:0] funct;
		} r;
		struct packed {
			logic [5:0] opcode;
			logic [regAddrWidth-1:0] rs;
			logic [regAddrWidth-1:0] rt;
			logic [15:0] imm;
		} i;
	} instrT;

	localparam instrT nop = '0; // decodes as a bubble

endpackage

`default_nettype wire

// ==== rtl/dataMem.sv ====
`timescale 1ns/1ps
`default_nettype none

module dataMem #(
	parameter int dmemDepth = 64
) (
	input logic clk,
	input logic [cpuPkg::dataWidth-1:0] addr, // byte address from ALU
	input logic [cpuPkg::dataWidth-1:0] wrData,
	input logic memWrite,
	output logic [cpuPkg::dataWidth-1:0] rdData
);

	localparam int dmemAw = $clog2(dmemDepth);

	logic [cpuPkg::dataWidth-1:0] mem [dmemDepth];
	logic [dmemAw-1:0] wordIdx;

	assign wordIdx = addr[dmemAw+1:2];

	always_ff @(posedge clk)
	begin
		if (memWrite)
			mem[wordIdx] <= wrData;
	end

	// read every cycle, only lw results get used
	assign rdData = mem[wordIdx];

	// high address bits are dropped by wordIdx, so a store past
	// the array would silently alias a low word
	storeInRange: assert property (@(posedge clk)
		memWrite |-> addr[cpuPkg::dataWidth-1:2] < dmemDepth)
		else $error("store to %h outside data memory", addr);

endmodule

`default_nettype wire

// ==== rtl/executeStage.sv ====
`timescale 1ns/1ps
`default_nettype none

module executeStage (
	input logic [1:0] aluOp,
	input logic [5:0] funct,
	input logic aluSrc,
	input logic [cpuPkg::dataWidth-1:0] opA, // ID/EX register values
	input logic [cpuPkg::dataWidth-1:0] opB,
	input logic [15:0] imm,
	input logic [1:0] fwdA,
	input logic [1:0] fwdB,
	input logic [cpuPkg::dataWidth-1:0] memFwd, // EX/MEM ALU result
	input logic [cpuPkg::dataWidth-1:0] wbFwd, // value being written back
	output logic [cpuPkg::dataWidth-1:0] aluResult,
	output logic [cpuPkg::dataWidth-1:0] storeValue
);

	logic [cpuPkg::dataWidth-1:0] srcA, srcB, immExt;
	logic [3:0] aluCtl;

	function automatic logic [cpuPkg::dataWidth-1:0] fwdMux(
		input logic [1:0] sel,
		input logic [cpuPkg::dataWidth-1:0] regVal,
		input logic [cpuPkg::dataWidth-1:0] memVal,
		input logic [cpuPkg::dataWidth-1:0] wbVal
	);
		case (sel)
			cpuPkg::fwdMem: return memVal;
			cpuPkg::fwdWb: return wbVal;
			default: return regVal;
		endcase
	endfunction

	assign srcA = fwdMux(fwdA, opA, memFwd, wbFwd);
	assign storeValue = fwdMux(fwdB, opB, memFwd, wbFwd); // sw data, rt after bypass
	assign immExt = {{(cpuPkg::dataWidth-16){imm[15]}}, imm};
	assign srcB = aluSrc ? immExt : storeValue;

	// ALU control
	always_comb
	begin
		case (aluOp)
			cpuPkg::aluClassSub: aluCtl = cpuPkg::aluSub;
			cpuPkg::aluClassFunct:
			begin
				case (funct)
					cpuPkg::fnSub: aluCtl = cpuPkg::aluSub;
					cpuPkg::fnAnd: aluCtl = cpuPkg::aluAnd;
					cpuPkg::fnOr: aluCtl = cpuPkg::aluOr;
					cpuPkg::fnSlt: aluCtl = cpuPkg::aluSlt;
					default: aluCtl = cpuPkg::aluAdd; // fnAdd
				endcase
			end
			default: aluCtl = cpuPkg::aluAdd; // address calc
		endcase
	end

	always_comb
	begin
		case (aluCtl)
			cpuPkg::aluAdd: aluResult = srcA + srcB;
			cpuPkg::aluSub: aluResult = srcA - srcB;
			cpuPkg::aluAnd: aluResult = srcA & srcB;
			cpuPkg::aluOr: aluResult = srcA | srcB;
			cpuPkg::aluSlt:
				aluResult = {{(cpuPkg::dataWidth-1){1'b0}}, $signed(srcA) < $signed(srcB)};
			default: aluResult = '0;
		endcase
	end

endmodule

`default_nettype wire

// ==== rtl/hazardUnit.sv ====
`timescale 1ns/1ps
`default_nettype none

module hazardUnit (
	input logic clk,
	input logic rstN,
	input logic [cpuPkg::regAddrWidth-1:0] rs, // decode stage
	input logic [cpuPkg::regAddrWidth-1:0] rt,
	input logic branch,
	input logic exMemRead,
	input logic exRegWrite,
	input logic [cpuPkg::regAddrWidth-1:0] exDest,
	input logic [cpuPkg::regAddrWidth-1:0] exRs,
	input logic [cpuPkg::regAddrWidth-1:0] exRt,
	input logic memRegWrite,
	input logic [cpuPkg::regAddrWidth-1:0] memDest,
	input logic wbRegWrite,
	input logic [cpuPkg::regAddrWidth-1:0] wbDest,
	output logic stall,
	output logic [1:0] fwdA,
	output logic [1:0] fwdB
);

	logic exWrites, memWrites, wbWrites;
	logic exHit, memHit; // producer matches a decode operand
	logic loadUse, branchWait;

	// writes to $0 never create a dependency
	assign exWrites = exRegWrite && (exDest != '0);
	assign memWrites = memRegWrite && (memDest != '0);
	assign wbWrites = wbRegWrite && (wbDest != '0);

	assign exHit = (exDest == rs) || (exDest == rt);
	assign memHit = (memDest == rs) || (memDest == rt);

	// one bubble lets the loaded word reach WB before the use enters EX
	assign loadUse = exMemRead && exWrites && exHit;
	// no bypass into the comparator, so beq waits until WB writes through
	assign branchWait = branch && ((exWrites && exHit) || (memWrites && memHit));
	assign stall = loadUse || branchWait;

	// nearest producer wins
	assign fwdA = (memWrites && memDest == exRs) ? cpuPkg::fwdMem :
		(wbWrites && wbDest == exRs) ? cpuPkg::fwdWb : cpuPkg::fwdNone;
	assign fwdB = (memWrites && memDest == exRt) ? cpuPkg::fwdMem :
		(wbWrites && wbDest == exRt) ? cpuPkg::fwdWb : cpuPkg::fwdNone;

	// any producer leaves EX and MEM behind bubbles within two cycles
	stallBounded: assert property (@(posedge clk) disable iff (!rstN)
		stall ##1 stall |=> !stall)
		else $error("stall held for more than two cycles");

endmodule

`default_nettype wire

// ==== rtl/instMem.sv ====
`timescale 1ns/1ps
`default_nettype none

module instMem #(
	parameter int imemDepth = 64
) (
	input logic clk,
	input logic rstN,
	input logic progWe,
	input logic [$clog2(imemDepth)-1:0] progAddr, // word index
	input logic [cpuPkg::dataWidth-1:0] progData,
	input logic [cpuPkg::dataWidth-1:0] pc, // byte address
	output logic [cpuPkg::dataWidth-1:0] instr
);

	localparam int imemAw = $clog2(imemDepth);

	logic [cpuPkg::dataWidth-1:0] mem [imemDepth];
	logic [imemAw-1:0] fetchIdx;

	assign fetchIdx = pc[imemAw+1:2]; // drop byte offset
	assign instr = mem[fetchIdx];

	// program load, only while the core sits in reset
	always_ff @(posedge clk)
	begin
		if (progWe)
			mem[progAddr] <= progData;
	end

	// pc must not run past the loaded array
	fetchInRange: assert property (@(posedge clk) disable iff (!rstN)
		pc[cpuPkg::dataWidth-1:2] < imemDepth)
		else $error("fetch index beyond instruction memory, pc %h", pc);

endmodule

`default_nettype wire

// ==== rtl/pipelineCpu.sv ====
`timescale 1ns/1ps
`default_nettype none

module pipelineCpu #(
	parameter int imemDepth = 64,
	parameter int dmemDepth = 64
) (
	input logic clk,
	input logic rstN,
	input logic progWe,
	input logic [$clog2(imemDepth)-1:0] progAddr,
	input logic [cpuPkg::dataWidth-1:0] progData,
	output logic wbEn,
	output logic [cpuPkg::regAddrWidth-1:0] wbReg,
	output logic [cpuPkg::dataWidth-1:0] wbData,
	output logic storeEn,
	output logic [cpuPkg::dataWidth-1:0] storeAddr,
	output logic [cpuPkg::dataWidth-1:0] storeData
);

	localparam int dw = cpuPkg::dataWidth;
	localparam int aw = cpuPkg::regAddrWidth;

	// IF
	logic [dw-1:0] pc, pcPlus4, instrWord;
	// ID
	cpuPkg::instrT ifIdInstr;
	logic regWrite, regDst, aluSrc, memRead, memWrite, memToReg, branch;
	logic [1:0] aluOp;
	logic [dw-1:0] rsData, rtData, immExt, branchTarget;
	logic [aw-1:0] decDest;
	logic stall, takeBranch;
	// ID/EX
	logic idExRegWrite, idExAluSrc, idExMemRead, idExMemWrite, idExMemToReg;
	logic [1:0] idExAluOp;
	logic [dw-1:0] idExOpA, idExOpB;
	logic [15:0] idExImm;
	logic [5:0] idExFunct;
	logic [aw-1:0] idExRs, idExRt, idExDest;
	logic [1:0] fwdA, fwdB;
	logic [dw-1:0] aluResult, storeValue;
	// EX/MEM
	logic exMemRegWrite, exMemMemWrite, exMemMemToReg;
	logic [dw-1:0] exMemAluResult, exMemStoreValue, memRdData;
	logic [aw-1:0] exMemDest;
	// MEM/WB
	logic memWbRegWrite, memWbMemToReg;
	logic [dw-1:0] memWbAluResult, memWbRdData, wbValue;
	logic [aw-1:0] memWbDest;

	instMem #(.imemDepth(imemDepth)) uInstMem (
		.clk(clk), .rstN(rstN), .progWe(progWe), .progAddr(progAddr),
		.progData(progData), .pc(pc), .instr(instrWord)
	);

	assign pcPlus4 = pc + dw'(4);

	always_ff @(posedge clk)
	begin
		if (!rstN)
		begin
			pc <= '0;
			ifIdInstr <= cpuPkg::nop;
		end
		else if (!stall) // stall freezes PC and IF/ID
		begin
			pc <= takeBranch ? branchTarget : pcPlus4;
			ifIdInstr <= takeBranch ? cpuPkg::nop : instrWord; // flush the slot
		end
	end

	controlUnit uControl (
		.instr(ifIdInstr), .regWrite(regWrite), .regDst(regDst), .aluSrc(aluSrc),
		.memRead(memRead), .memWrite(memWrite), .memToReg(memToReg),
		.branch(branch), .aluOp(aluOp)
	);

	regFile uRegFile (
		.clk(clk), .rstN(rstN), .rsAddr(ifIdInstr.r.rs), .rtAddr(ifIdInstr.r.rt),
		.wrAddr(memWbDest), .wrData(wbValue), .wrEn(memWbRegWrite),
		.rsData(rsData), .rtData(rtData)
	);

	hazardUnit uHazard (
		.clk(clk), .rstN(rstN), .rs(ifIdInstr.r.rs), .rt(ifIdInstr.r.rt),
		.branch(branch), .exMemRead(idExMemRead), .exRegWrite(idExRegWrite),
		.exDest(idExDest), .exRs(idExRs), .exRt(idExRt),
		.memRegWrite(exMemRegWrite), .memDest(exMemDest),
		.wbRegWrite(memWbRegWrite), .wbDest(memWbDest),
		.stall(stall), .fwdA(fwdA), .fwdB(fwdB)
	);

	assign decDest = regDst ? ifIdInstr.r.rd : ifIdInstr.i.rt;
	assign immExt = {{(dw-16){ifIdInstr.i.imm[15]}}, ifIdInstr.i.imm};
	// pc already points past the beq while it sits in ID, held there by any stall
	assign branchTarget = pc + {immExt[dw-3:0], 2'b00};
	assign takeBranch = branch && (rsData == rtData) && !stall;

	// ID/EX control, a stall inserts a bubble
	always_ff @(posedge clk)
	begin
		if (!rstN || stall)
		begin
			idExRegWrite <= 1'b0;
			idExAluSrc <= 1'b0;
			idExMemRead <= 1'b0;
			idExMemWrite <= 1'b0;
			idExMemToReg <= 1'b0;
			idExAluOp <= cpuPkg::aluClassAdd;
		end
		else
		begin
			idExRegWrite <= regWrite;
			idExAluSrc <= aluSrc;
			idExMemRead <= memRead;
			idExMemWrite <= memWrite;
			idExMemToReg <= memToReg;
			idExAluOp <= aluOp;
		end
	end

	always_ff @(posedge clk)
	begin
		idExOpA <= rsData;
		idExOpB <= rtData;
		idExImm <= ifIdInstr.i.imm;
		idExFunct <= ifIdInstr.r.funct;
		idExRs <= ifIdInstr.r.rs;
		idExRt <= ifIdInstr.r.rt;
		idExDest <= decDest;
	end

	executeStage uExecute (
		.aluOp(idExAluOp), .funct(idExFunct), .aluSrc(idExAluSrc),
		.opA(idExOpA), .opB(idExOpB), .imm(idExImm), .fwdA(fwdA), .fwdB(fwdB),
		.memFwd(exMemAluResult), .wbFwd(wbValue),
		.aluResult(aluResult), .storeValue(storeValue)
	);

	// EX/MEM and MEM/WB control
	always_ff @(posedge clk)
	begin
		if (!rstN)
		begin
			exMemRegWrite <= 1'b0;
			exMemMemWrite <= 1'b0;
			exMemMemToReg <= 1'b0;
			memWbRegWrite <= 1'b0;
			memWbMemToReg <= 1'b0;
		end
		else
		begin
			exMemRegWrite <= idExRegWrite;
			exMemMemWrite <= idExMemWrite;
			exMemMemToReg <= idExMemToReg;
			memWbRegWrite <= exMemRegWrite;
			memWbMemToReg <= exMemMemToReg;
		end
	end

	always_ff @(posedge clk)
	begin
		exMemAluResult <= aluResult;
		exMemStoreValue <= storeValue;
		exMemDest <= idExDest;
		memWbAluResult <= exMemAluResult;
		memWbRdData <= memRdData;
		memWbDest <= exMemDest;
	end

	dataMem #(.dmemDepth(dmemDepth)) uDataMem (
		.clk(clk), .addr(exMemAluResult), .wrData(exMemStoreValue),
		.memWrite(exMemMemWrite), .rdData(memRdData)
	);

	assign wbValue = memWbMemToReg ? memWbRdData : memWbAluResult;

	// observation ports
	assign wbEn = memWbRegWrite;
	assign wbReg = memWbDest;
	assign wbData = wbValue;
	assign storeEn = exMemMemWrite;
	assign storeAddr = exMemAluResult;
	assign storeData = exMemStoreValue;

	// a redirect lands while the pipe moves, and the flushed slot raises no stall
	branchFlush: assert property (@(posedge clk) disable iff (!rstN)
		takeBranch |=> !stall && ifIdInstr == cpuPkg::nop)
		else $error("taken branch overlapped a stall or left IF/ID unflushed");

endmodule

`default_nettype wire

// ==== rtl/regFile.sv ====
`timescale 1ns/1ps
`default_nettype none

module regFile (
	input logic clk,
	input logic rstN,
	input logic [cpuPkg::regAddrWidth-1:0] rsAddr,
	input logic [cpuPkg::regAddrWidth-1:0] rtAddr,
	input logic [cpuPkg::regAddrWidth-1:0] wrAddr,
	input logic [cpuPkg::dataWidth-1:0] wrData,
	input logic wrEn,
	output logic [cpuPkg::dataWidth-1:0] rsData,
	output logic [cpuPkg::dataWidth-1:0] rtData
);

	localparam int numRegs = 2 ** cpuPkg::regAddrWidth;

	logic [cpuPkg::dataWidth-1:0] regs [numRegs];
	logic wrLive; // write that actually lands

	assign wrLive = wrEn && (wrAddr != '0); // $0 stays zero

	always_ff @(posedge clk)
	begin
		if (!rstN)
		begin
			for (int k = 0; k < numRegs; k++)
				regs[k] <= '0;
		end
		else if (wrLive)
			regs[wrAddr] <= wrData;
	end

	// WB and ID share a cycle, so bypass the write to readers
	// of the same index instead of splitting the clock
	assign rsData = (wrLive && wrAddr == rsAddr) ? wrData : regs[rsAddr];
	assign rtData = (wrLive && wrAddr == rtAddr) ? wrData : regs[rtAddr];

endmodule

`default_nettype wire

// ==== run.sh ====
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -j 0 -f tb.f --top-module cpuTb -o cpuSim

simOut=$(./obj_dir/cpuSim 2>&1) || true
echo "$simOut"

if echo "$simOut" | grep -q "^TESTS PASSED$"; then
	exit 0
fi
exit 1

// ==== tb.f ====
rtl/cpuPkg.sv
rtl/instMem.sv
rtl/regFile.sv
rtl/controlUnit.sv
rtl/hazardUnit.sv
rtl/executeStage.sv
rtl/dataMem.sv
rtl/pipelineCpu.sv
tb/clkGen.sv
tb/cpuTb.sv

// ==== tb/clkGen.sv ====
`timescale 1ns/1ps
`default_nettype none

module clkGen #(
	parameter int halfPeriod = 4 // ns, 8 ns period
) (
	output logic clk
);

	initial
	begin
		clk = 1'b0;
		forever
			#halfPeriod clk = ~clk;
	end

endmodule

`default_nettype wire

// ==== tb/cpuTb.sv ====
`timescale 1ns/1ps
`default_nettype none

module cpuTb;

	localparam int imemDepth = 64;
	localparam int dmemDepth = 64;
	localparam int progAw = $clog2(imemDepth);
	localparam int progLen = 16;
	localparam int resetCycles = 16;
	localparam int drainCycles = 8; // watch for stray pulses after the last result
	localparam int timeoutCycles = 3 * progLen + resetCycles + 8;

	logic clk, rstN, progWe;
	logic [progAw-1:0] progAddr;
	logic [31:0] progData;
	logic wbEn, storeEn;
	logic [4:0] wbReg;
	logic [31:0] wbData, storeAddr, storeData;

	// program and expectation table, one row per instruction word
	logic [31:0] progWord [progLen];
	string rowName [progLen];
	logic wantWb [progLen];
	logic [4:0] wantReg [progLen];
	logic [31:0] wantVal [progLen];
	logic wantSt [progLen];
	logic [31:0] wantAddr [progLen];
	logic [31:0] wantData [progLen];
	int pending [$]; // rows still owed a pulse, program order

	logic [31:0] lfsrState, d0, d1;
	logic [15:0] storeOff;
	int edgeCount = 0; // edges since reset release
	int cycleCount = 0;
	int testCount = 0;
	int errCount = 0;
	logic firstSeen = 1'b0;

	clkGen uClk (.clk(clk));

	pipelineCpu #(.imemDepth(imemDepth), .dmemDepth(dmemDepth)) dut (
		.clk(clk), .rstN(rstN), .progWe(progWe), .progAddr(progAddr), .progData(progData),
		.wbEn(wbEn), .wbReg(wbReg), .wbData(wbData),
		.storeEn(storeEn), .storeAddr(storeAddr), .storeData(storeData)
	);

	function automatic logic [31:0] lfsrStep(input logic [31:0] s);
		return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1); // taps 32 22 2 1
	endfunction

	// one LFSR step per bit handed out
	function automatic logic [31:0] takeBits(input int n);
		logic [31:0] v;
		v = '0;
		for (int k = 0; k < n; k++)
		begin
			v = {v[30:0], lfsrState[0]};
			lfsrState = lfsrStep(lfsrState);
		end
		return v;
	endfunction

	function automatic logic [31:0] encR(input logic [4:0] rs, input logic [4:0] rt,
		input logic [4:0] rd, input logic [5:0] funct);
		return {cpuPkg::opR, rs, rt, rd, 5'd0, funct};
	endfunction

	function automatic logic [31:0] encI(input logic [5:0] op, input logic [4:0] rs,
		input logic [4:0] rt, input logic [15:0] imm);
		return {op, rs, rt, imm};
	endfunction

	task automatic putRow(input int idx, input string name, input logic [31:0] word,
		input logic wb, input logic [4:0] rd, input logic [31:0] val,
		input logic st, input logic [31:0] addr, input logic [31:0] data);
		progWord[idx] = word;
		rowName[idx] = name;
		wantWb[idx] = wb;
		wantReg[idx] = rd;
		wantVal[idx] = val;
		wantSt[idx] = st;
		wantAddr[idx] = addr;
		wantData[idx] = data;
		if (wb || st)
			pending.push_back(idx);
	endtask

	// expected values follow the ISA in program order, registers start at zero
	task automatic buildTable();
		logic [31:0] r3, r4, r5, r6, r8;
		r3 = d0 | d1;
		r4 = r3 - d0;
		r5 = r4 & r3;
		r6 = {31'd0, $signed(d0) < $signed(d1)}; // signed compare
		r8 = r5 | d0; // same bits as r3
		putRow(0, "lw $1", encI(cpuPkg::opLw, 5'd0, 5'd1, 16'd0), 1'b1, 5'd1, d0, 1'b0, '0, '0);
		putRow(1, "lw $2", encI(cpuPkg::opLw, 5'd0, 5'd2, 16'd4), 1'b1, 5'd2, d1, 1'b0, '0, '0);
		putRow(2, "or $3 after load", encR(5'd1, 5'd2, 5'd3, cpuPkg::fnOr),
			1'b1, 5'd3, r3, 1'b0, '0, '0);
		putRow(3, "sub $4 fwd from MEM", encR(5'd3, 5'd1, 5'd4, cpuPkg::fnSub),
			1'b1, 5'd4, r4, 1'b0, '0, '0);
		putRow(4, "and $5 fwd MEM and WB", encR(5'd4, 5'd3, 5'd5, cpuPkg::fnAnd),
			1'b1, 5'd5, r5, 1'b0, '0, '0);
		putRow(5, "slt $6", encR(5'd1, 5'd2, 5'd6, cpuPkg::fnSlt), 1'b1, 5'd6, r6, 1'b0, '0, '0);
		putRow(6, "sw $5", encI(cpuPkg::opSw, 5'd0, 5'd5, storeOff),
			1'b0, 5'd0, '0, 1'b1, {16'd0, storeOff}, r5);
		putRow(7, "lw $7 reload", encI(cpuPkg::opLw, 5'd0, 5'd7, storeOff),
			1'b1, 5'd7, r5, 1'b0, '0, '0);
		putRow(8, "or $8 load use", encR(5'd7, 5'd1, 5'd8, cpuPkg::fnOr),
			1'b1, 5'd8, r8, 1'b0, '0, '0);
		// $8 still reads 0 until row 8 writes back, and $3 is never 0
		putRow(9, "beq $8 $3 taken", encI(cpuPkg::opBeq, 5'd8, 5'd3, 16'd1),
			1'b0, 5'd0, '0, 1'b0, '0, '0);
		putRow(10, "add $9 flushed", encR(5'd1, 5'd1, 5'd9, cpuPkg::fnAdd),
			1'b0, 5'd0, '0, 1'b0, '0, '0); // skipped by row 9, no pulse
		putRow(11, "beq $1 $2 not taken", encI(cpuPkg::opBeq, 5'd1, 5'd2, 16'd1),
			1'b0, 5'd0, '0, 1'b0, '0, '0);
		putRow(12, "add $10", encR(5'd2, 5'd2, 5'd10, cpuPkg::fnAdd), 1'b1, 5'd10, d1 + d1,
			1'b0, '0, '0);
		putRow(13, "sub $11", encR(5'd2, 5'd1, 5'd11, cpuPkg::fnSub), 1'b1, 5'd11, d1 - d0,
			1'b0, '0, '0);
		putRow(14, "and $12", encR(5'd2, 5'd1, 5'd12, cpuPkg::fnAnd), 1'b1, 5'd12, d1 & d0,
			1'b0, '0, '0);
		putRow(15, "or $13", encR(5'd2, 5'd1, 5'd13, cpuPkg::fnOr), 1'b1, 5'd13, d1 | d0,
			1'b0, '0, '0);
	endtask

	task automatic checkWb();
		int row;
		logic due;
		due = 1'b0;
		if (pending.size() > 0)
			due = wantWb[pending[0]];
		assert (due) else
		begin
			$display("unexpected register write of %h to $%0d at %0t ns, none was due",
				wbData, wbReg, $time);
			errCount++;
		end
		if (!firstSeen)
		begin
			firstSeen = 1'b1;
			testCount++;
			// first word enters IF/ID at edge 1 and reaches MEM/WB at edge 4
			assert (edgeCount == 4) $display("first writeback at edge %0d ok", edgeCount);
			else
			begin
				$display("** Error at %0t ns: first writeback at edge %0d, expected 4",
					$time, edgeCount);
				errCount++;
			end
		end
		if (due)
		begin
			row = pending.pop_front();
			testCount++;
			assert (wbReg == wantReg[row] && wbData == wantVal[row])
				$display("%s ok, $%0d = %h", rowName[row], wbReg, wbData);
			else
			begin
				$display("** Error at %0t ns: %s wrote $%0d = %h, expected $%0d = %h",
					$time, rowName[row], wbReg, wbData, wantReg[row], wantVal[row]);
				errCount++;
			end
		end
	endtask

	task automatic checkStore();
		int row;
		logic due;
		due = 1'b0;
		if (pending.size() > 0)
			due = wantSt[pending[0]];
		assert (due) else
		begin
			$display("unexpected store of %h to %h at %0t ns, none was due",
				storeData, storeAddr, $time);
			errCount++;
		end
		if (due)
		begin
			row = pending.pop_front();
			testCount++;
			assert (storeAddr == wantAddr[row] && storeData == wantData[row])
				$display("%s ok, [%h] = %h", rowName[row], storeAddr, storeData);
			else
			begin
				$display("** Error at %0t ns: %s stored %h at %h, expected %h at %h", $time,
					rowName[row], storeData, storeAddr, wantData[row], wantAddr[row]);
				errCount++;
			end
		end
	endtask

	always @(posedge clk)
	begin
		cycleCount <= cycleCount + 1;
		if (rstN)
			edgeCount <= edgeCount + 1;
	end

	// outputs settle by the falling edge
	always @(negedge clk)
	begin
		if (!rstN)
		begin
			assert (!wbEn && !storeEn) else
			begin
				$display("** Error at %0t ns: output pulse while in reset", $time);
				errCount++;
			end
		end
		else
		begin
			if (wbEn)
				checkWb(); // WB holds the older instruction, so it goes first
			if (storeEn)
				checkStore();
		end
	end

	initial
	begin
		lfsrState = 32'h9c6c_58f0;
		d0 = takeBits(32);
		d1 = takeBits(32);
		if (d1 == d0)
			d1 = ~d0; // the not-taken beq needs them apart
		storeOff = 16'(32'd8 + 32'd4 * takeBits(5)); // clear of words 0 and 1
		buildTable();
		rstN = 1'b0;
		progWe = 1'b1;
		progAddr = '0;
		progData = progWord[0];
		// no immediate ALU op, so the operands start in data memory
		dut.uDataMem.mem[0] <= d0;
		dut.uDataMem.mem[1] <= d1;
		for (int i = 1; i < progLen; i++)
		begin
			@(posedge clk);
			progAddr <= i[progAw-1:0];
			progData <= progWord[i];
		end
		@(posedge clk); // 16th reset edge writes the last word
		progWe <= 1'b0;
		rstN <= 1'b1;
		while (pending.size() != 0)
			@(posedge clk);
		repeat (drainCycles)
			@(posedge clk);
		$display("%0d tests, %0d errors", testCount, errCount);
		if (errCount == 0)
			$display("TESTS PASSED");
		else
			$display("TESTS FAILED");
		$finish;
	end

	initial
	begin
		while (cycleCount < timeoutCycles)
			@(posedge clk);
		$display("timeout after %0d cycles, %0d expected results never appeared",
			timeoutCycles, pending.size());
		$display("%0d tests, %0d errors", testCount, errCount);
		$display("TESTS FAILED");
		$finish;
	end

endmodule

`default_nettype wire
